//--- bench/id_stage_props.sv
// decode stage handshake assertions
`timescale 1ns/1ps
`default_nettype none

module id_stage_props
  import id_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst_n,
  input logic      i_fs_valid,
  input logic      i_ds_allowin,
  input logic      i_ds_to_es_valid,
  input ds_to_es_t i_ds_to_es,
  input logic      i_es_allowin,
  input logic      i_br_taken
);

  // packet held while execute stalls
  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ds_to_es_valid && !i_es_allowin |=> i_ds_to_es_valid &&
      $stable(i_ds_to_es.pc) && $stable(i_ds_to_es.imm) && $stable(i_ds_to_es.ctrl))
    else $error("decode packet changed under back-pressure");

  // wrong-path fetch word is dropped
  a_flush: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken && i_fs_valid && i_ds_allowin |=> !i_ds_to_es_valid)
    else $error("valid packet after a taken redirect");

  // stage left empty keeps allowin high
  a_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ds_allowin && (!i_fs_valid || i_br_taken) |=> i_ds_allowin)
    else $error("empty stage refused a fetch word");

endmodule

bind id_stage id_stage_props u_props (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_fs_valid       (i_fs_to_ds_valid),
  .i_ds_allowin     (o_ds_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_to_es       (o_ds_to_es),
  .i_es_allowin     (i_es_allowin),
  .i_br_taken       (br_taken)
);

`default_nettype wire

//--- bench/tb_id_stage.sv
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
  import id_pkg::*;
();

  typedef struct {
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] fpc;   // fetch pc while the word sits in decode
    bypass_t     es;
    bypass_t     ms;
    bypass_t     ws;
    logic        inv;
  } entry_t;

  localparam logic [31:0] NOP = 32'h0000_0013;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_fs_to_ds_valid;
  fs_to_ds_t   i_fs_to_ds;
  logic        o_ds_allowin;
  logic        o_ds_to_es_valid;
  ds_to_es_t   o_ds_to_es;
  logic        i_es_allowin;
  rf_write_t   i_rf_write;
  bypass_t     i_es_bypass;
  bypass_t     i_ms_bypass;
  bypass_t     i_ws_bypass;
  br_bus_t     o_br_bus;
  entry_t      table_q[$];
  logic [63:0] regs [0:31];
  integer      seed;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  id_stage i_dut (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds       (i_fs_to_ds),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es       (o_ds_to_es),
    .i_es_allowin     (i_es_allowin),
    .i_rf_write       (i_rf_write),
    .i_es_bypass      (i_es_bypass),
    .i_ms_bypass      (i_ms_bypass),
    .i_ws_bypass      (i_ws_bypass),
    .o_br_bus         (o_br_bus)
  );

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
    errors_at_start = errors;
  endtask

  // returns just after the edge that accepts the fetch word
  task automatic wait_allowin();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_ds_allowin && n < 20) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_ds_allowin) begin
      $display("timeout: decode stage never accepted the fetch word");
      errors++;
    end
    @(posedge i_clk);
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_ds_to_es_valid && n < 20) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_ds_to_es_valid) begin
      $display("timeout: decode stage never sent its packet to execute");
      errors++;
    end
  endtask

  function automatic bypass_t byp(input logic [4:0] rd, input logic [63:0] res);
    return '{rd: rd, result: res};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // rv64i decode rules, independent model
  task automatic ref_decode(input logic [31:0] inst, output ctrl_t c, output logic [63:0] imm);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    op  = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    c   = '0;
    ok  = 1'b1;
    imm = {{52{inst[31]}}, inst[31:20]};
    case (op)
      7'h33, 7'h3b: begin
        c.alu_op   = ref_alu(f3, f7[5]);
        c.word_cut = (op == 7'h3b);
        c.gpr_wen  = 1'b1;
        ok = (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) &&
             (op == 7'h33 || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
      end
      7'h13, 7'h1b: begin
        c.alu_op   = ref_alu(f3, f3 == 3'd5 && inst[30]);
        c.src2_sel = SRC2_IMM;
        c.word_cut = (op == 7'h1b);
        c.gpr_wen  = 1'b1;
        if (op == 7'h13 && (f3 == 3'd1 || f3 == 3'd5)) begin
          ok = inst[31:26] == 6'h00 || (inst[31:26] == 6'h10 && f3 == 3'd5);
        end else if (op == 7'h1b) begin
          ok = f3 == 3'd0 || ((f3 == 3'd1 || f3 == 3'd5) &&
               (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5)));
        end
      end
      7'h37, 7'h17: begin
        c.alu_op   = (op == 7'h37) ? ALU_PASS_B : ALU_ADD;
        c.src1_sel = (op == 7'h37) ? SRC1_RS1 : SRC1_PC;
        c.src2_sel = SRC2_IMM;
        c.gpr_wen  = 1'b1;
        imm        = {{32{inst[31]}}, inst[31:12], 12'h0};
      end
      7'h6f, 7'h67: begin
        c.src1_sel = SRC1_PC;
        c.src2_sel = SRC2_FOUR;
        c.bren     = 1'b1;
        c.br_func  = (op == 7'h6f) ? BR_JAL : BR_JALR;
        c.gpr_wen  = 1'b1;
        if (op == 7'h6f) begin
          imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        ok = (op == 7'h6f) || (f3 == 3'd0);
      end
      7'h63: begin
        c.bren = 1'b1;
        imm    = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        case (f3)
          3'd0:    c.br_func = BR_BEQ;
          3'd1:    c.br_func = BR_BNE;
          3'd4:    c.br_func = BR_BLT;
          3'd5:    c.br_func = BR_BGE;
          3'd6:    c.br_func = BR_BLTU;
          3'd7:    c.br_func = BR_BGEU;
          default: ok = 1'b0;
        endcase
      end
      7'h03: begin
        c.src2_sel = SRC2_IMM;
        c.mem_ren  = 1'b1;
        c.gpr_wen  = 1'b1;
        c.mem_op   = mem_op_e'(f3);
        ok         = (f3 != 3'd7);
      end
      7'h23: begin
        c.src2_sel = SRC2_IMM;
        c.mem_wen  = 1'b1;
        c.mem_op   = mem_op_e'(f3);
        imm        = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        ok         = (f3 < 3'd4);
      end
      7'h73: begin
        ok       = (inst == 32'h0010_0073);
        c.ebreak = ok;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      c         = '0;
      c.invalid = 1'b1;
      imm       = '0;
    end
    c.rd = c.gpr_wen ? inst[11:7] : 5'd0;
  endtask

  // execute, then memory, then write-back, then registers
  function automatic logic [63:0] exp_operand(input logic [4:0] rs, input entry_t e);
    if (rs == 5'd0) return 64'd0;
    if (e.es.rd == rs) return e.es.result;
    if (e.ms.rd == rs) return e.ms.result;
    if (e.ws.rd == rs) return e.ws.result;
    return regs[rs];
  endfunction

  task automatic add_entry(input logic [31:0] inst, input logic [63:0] pc, input logic [63:0] fpc,
      input bypass_t es, input bypass_t ms, input bypass_t ws, input logic inv);
    entry_t e;
    e = '{inst: inst, pc: pc, fpc: fpc, es: es, ms: ms, ws: ws, inv: inv};
    table_q.push_back(e);
  endtask

  task automatic fill_table();
    add_entry(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd3, 7'h33), 64'h1000, 64'h1004, '0, '0, '0, 0);
    add_entry(enc_r(7'h00, 5'd31, 5'd0, 3'd0, 5'd2, 7'h33), 64'h1010, 64'h1014, '0, '0, '0, 0);
    add_entry(enc_r(7'h20, 5'd8, 5'd7, 3'd0, 5'd4, 7'h33), 64'h1020, 64'h1024, '0, '0, '0, 0);
    add_entry(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd9, 7'h33), 64'h1030, 64'h1034, '0, '0, '0, 0);
    add_entry(enc_r(7'h00, 5'd13, 5'd12, 3'd3, 5'd11, 7'h33), 64'h1040, 64'h1044, '0, '0, '0, 0);
    add_entry(enc_r(7'h00, 5'd16, 5'd15, 3'd0, 5'd14, 7'h3b), 64'h1050, 64'h1054, '0, '0, '0, 0);
    add_entry(enc_r(7'h20, 5'd19, 5'd18, 3'd5, 5'd17, 7'h3b), 64'h1060, 64'h1064, '0, '0, '0, 0);
    add_entry(enc_i(12'hffb, 5'd18, 3'd0, 5'd17, 7'h13), 64'h1070, 64'h1074, '0, '0, '0, 0);
    add_entry(enc_i(12'h43f, 5'd20, 3'd5, 5'd19, 7'h13), 64'h1080, 64'h1084, '0, '0, '0, 0);
    add_entry(enc_i(12'h01f, 5'd22, 3'd1, 5'd21, 7'h1b), 64'h1090, 64'h1094, '0, '0, '0, 0);
    add_entry(enc_u(20'h80000, 5'd23, 7'h37), 64'h10a0, 64'h10a4, '0, '0, '0, 0);
    add_entry(enc_u(20'h12345, 5'd24, 7'h17), 64'h10b0, 64'h10b4, '0, '0, '0, 0);
    add_entry(enc_i(12'hff8, 5'd26, 3'd3, 5'd25, 7'h03), 64'h10c0, 64'h10c4, '0, '0, '0, 0);
    add_entry(enc_i(12'h005, 5'd28, 3'd4, 5'd27, 7'h03), 64'h10d0, 64'h10d4, '0, '0, '0, 0);
    add_entry(enc_s(12'h7f0, 5'd28, 5'd29, 3'd2, 7'h23), 64'h10e0, 64'h10e4, '0, '0, '0, 0);
    add_entry(enc_s(12'hffc, 5'd30, 5'd1, 3'd3, 7'h23), 64'h10f0, 64'h10f4, '0, '0, '0, 0);
    // forwarding priority and x0 never forwarded
    add_entry(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd3, 7'h33), 64'h1100, 64'h1104,
              byp(5, 64'haaaa), byp(5, 64'hbbbb), byp(6, 64'hcccc), 0);
    add_entry(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd3, 7'h33), 64'h1110, 64'h1114,
              byp(7, 64'hdddd), byp(5, 64'hbbbb), byp(5, 64'hcccc), 0);
    add_entry(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, 7'h33), 64'h1120, 64'h1124,
              byp(0, '1), byp(0, '1), byp(0, '1), 0);
    // branches and jumps
    add_entry(enc_b(13'h0040, 5'd6, 5'd5, 3'd0), 64'h2000, 64'h2004,
              byp(5, 64'h55), byp(6, 64'h55), '0, 0);
    add_entry(enc_b(13'h0040, 5'd6, 5'd5, 3'd1), 64'h2100, 64'h2104,
              byp(5, 64'h55), byp(6, 64'h55), '0, 0);
    add_entry(enc_b(13'h1ff0, 5'd6, 5'd5, 3'd4), 64'h2200, 64'h2204, byp(5, '1), byp(6, 1), '0, 0);
    add_entry(enc_b(13'h1ff0, 5'd6, 5'd5, 3'd5), 64'h2300, 64'h2308, byp(5, '1), byp(6, 1), '0, 0);
    add_entry(enc_b(13'h0100, 5'd6, 5'd5, 3'd6), 64'h2400, 64'h2404, byp(5, '1), byp(6, 1), '0, 0);
    add_entry(enc_b(13'h0100, 5'd6, 5'd5, 3'd7), 64'h2500, 64'h2504, byp(5, '1), byp(6, 1), '0, 0);
    add_entry(enc_j(21'h000800, 5'd1), 64'h2600, 64'h2604, '0, '0, '0, 0);
    add_entry(enc_i(12'h004, 5'd5, 3'd0, 5'd1, 7'h67), 64'h2700, 64'h7004,
              byp(5, 64'h7001), '0, '0, 0);
    // unsupported encodings
    add_entry(32'hffff_ffff, 64'h3000, 64'h3004, '0, '0, '0, 1);
    add_entry(enc_b(13'h0010, 5'd6, 5'd5, 3'd2), 64'h3010, 64'h3014, '0, '0, '0, 1);
    add_entry(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), 64'h3020, 64'h3024, '0, '0, '0, 1);
    add_entry(enc_i(12'h000, 5'd1, 3'd7, 5'd2, 7'h03), 64'h3030, 64'h3034, '0, '0, '0, 1);
    add_entry(32'h0000_0073, 64'h3040, 64'h3044, '0, '0, '0, 1);
    add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3, 7'h3b), 64'h3050, 64'h3054, '0, '0, '0, 1);
  endtask

  task automatic write_regs();
    logic [63:0] d;
    for (int r = 0; r < 32; r++) begin
      @(posedge i_clk);
      #1;
      d = {$random(seed), $random(seed)};
      i_rf_write = '{wen: 1'b1, waddr: r[4:0], wdata: d};
      if (r != 0) regs[r] = d;  // x0 write must be ignored
    end
    @(posedge i_clk);
    #1;
    i_rf_write.wen = 1'b0;
  endtask

  task automatic run_entry(input entry_t e);
    ctrl_t       c;
    logic [63:0] imm;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] tgt;
    logic        cond;
    logic        taken;
    ref_decode(e.inst, c, imm);
    a = exp_operand(e.inst[19:15], e);
    b = exp_operand(e.inst[24:20], e);
    case (c.br_func)
      BR_BEQ:  cond = (a == b);
      BR_BNE:  cond = (a != b);
      BR_BLT:  cond = ($signed(a) < $signed(b));
      BR_BGE:  cond = ($signed(a) >= $signed(b));
      BR_BLTU: cond = (a < b);
      BR_BGEU: cond = (a >= b);
      default: cond = 1'b1;
    endcase
    tgt   = (c.br_func == BR_JALR) ? ((a + imm) & ~64'h1) : (cond ? e.pc + imm : e.pc + 64'd4);
    taken = c.bren && (tgt != e.fpc);
    @(posedge i_clk);
    #1;
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds       = '{inst: e.inst, pc: e.pc};
    i_es_bypass      = e.es;
    i_ms_bypass      = e.ms;
    i_ws_bypass      = e.ws;
    wait_allowin();
    #1;
    i_fs_to_ds = '{inst: NOP, pc: e.fpc};
    @(negedge i_clk);
    check("o_ds_to_es_valid", o_ds_to_es_valid, 1'b1);
    check("o_ds_to_es.pc", o_ds_to_es.pc, e.pc);
    check("o_ds_to_es.imm", o_ds_to_es.imm, imm);
    check("o_ds_to_es.ctrl", o_ds_to_es.ctrl, c);
    check("o_ds_to_es.ctrl.invalid", o_ds_to_es.ctrl.invalid, e.inv);
    check("o_ds_to_es.rs1_data", o_ds_to_es.rs1_data, a);
    check("o_ds_to_es.rs2_data", o_ds_to_es.rs2_data, b);
    check("o_br_bus.sel", o_br_bus.sel, c.bren);
    check("o_br_bus.taken", o_br_bus.taken, taken);
    if (c.bren) check("o_br_bus.target", o_br_bus.target, tgt);
    @(posedge i_clk);
    #1;
    i_fs_to_ds_valid = 1'b0;
    @(negedge i_clk);
    check("o_ds_to_es_valid", o_ds_to_es_valid, !taken);  // wrong-path slot dropped
  endtask

  task automatic back_pressure();
    @(posedge i_clk);
    #1;
    i_es_bypass      = '0;
    i_ms_bypass      = '0;
    i_ws_bypass      = '0;
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds       = '{inst: enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd3, 7'h33), pc: 64'h5000};
    wait_allowin();
    #1;
    i_fs_to_ds   = '{inst: NOP, pc: 64'h5004};
    i_es_allowin = 1'b0;
    repeat (3) begin
      @(negedge i_clk);
      check("o_ds_allowin", o_ds_allowin, 1'b0);
      check("o_ds_to_es_valid", o_ds_to_es_valid, 1'b1);
      check("o_ds_to_es.pc", o_ds_to_es.pc, 64'h5000);
      check("o_ds_to_es.rs1_data", o_ds_to_es.rs1_data, regs[5]);
    end
    @(posedge i_clk);
    #1;
    i_es_allowin = 1'b1;
    @(posedge i_clk);
    #1;
    i_fs_to_ds_valid = 1'b0;
    @(negedge i_clk);
    check("o_ds_to_es.pc", o_ds_to_es.pc, 64'h5004);
  endtask

  task automatic ebreak_stall();
    @(posedge i_clk);
    #1;
    i_es_bypass      = byp(10, 64'h1);
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds       = '{inst: 32'h0010_0073, pc: 64'h6000};
    wait_allowin();
    #1;
    i_fs_to_ds_valid = 1'b0;
    repeat (2) begin
      @(negedge i_clk);
      check("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
      check("o_ds_allowin", o_ds_allowin, 1'b0);
      check("o_ds_to_es.ctrl.ebreak", o_ds_to_es.ctrl.ebreak, 1'b1);
    end
    @(posedge i_clk);
    #1;
    i_es_bypass = '0;
    i_ws_bypass = byp(10, 64'h2);  // a0 still in write-back
    @(negedge i_clk);
    check("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    @(posedge i_clk);
    #1;
    i_ws_bypass = '0;
    wait_valid();
    check("o_ds_to_es.pc", o_ds_to_es.pc, 64'h6000);
    check("o_ds_allowin", o_ds_allowin, 1'b1);
  endtask

  initial begin
    seed             = 32'h1b50_fa86;
    errors           = 0;
    errors_at_start  = 0;
    tests_run        = 0;
    tests_failed     = 0;
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds       = '0;
    i_es_allowin     = 1'b1;
    i_rf_write       = '0;
    i_es_bypass      = '0;
    i_ms_bypass      = '0;
    i_ws_bypass      = '0;
    foreach (regs[i]) regs[i] = '0;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check("o_br_bus.sel", o_br_bus.sel, 1'b0);
    check("o_br_bus.taken", o_br_bus.taken, 1'b0);
    check("o_ds_allowin", o_ds_allowin, 1'b1);
    end_test("reset");
    write_regs();
    fill_table();
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
      end_test($sformatf("table entry %0d", i));
    end
    back_pressure();
    end_test("back-pressure");
    ebreak_stall();
    end_test("ebreak stall");
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- common/id_pkg.sv
// decode stage shared types
`default_nettype none

package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int IMM_WD      = 64;

  // ebreak holds while a0 still has a write in flight
  localparam logic [GPR_ADDR_WD-1:0] EBREAK_WAIT_REG = 5'd10;

  typedef enum logic [6:0] {
    OPC_LOAD       = 7'b0000011,
    OPC_OP_IMM     = 7'b0010011,
    OPC_AUIPC      = 7'b0010111,
    OPC_OP_IMM_32  = 7'b0011011,
    OPC_STORE      = 7'b0100011,
    OPC_OP         = 7'b0110011,
    OPC_LUI        = 7'b0110111,
    OPC_OP_32      = 7'b0111011,
    OPC_BRANCH     = 7'b1100011,
    OPC_JALR       = 7'b1100111,
    OPC_JAL        = 7'b1101111,
    OPC_SYSTEM     = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B          // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_func_e;

  // same order as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B, MEM_H, MEM_W, MEM_D, MEM_BU, MEM_HU, MEM_WU
  } mem_op_e;

  typedef enum logic       {SRC1_RS1, SRC1_PC} src1_sel_e;
  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_e                alu_op;
    src1_sel_e              src1_sel;
    src2_sel_e              src2_sel;
    logic                   word_cut;   // 32-bit result, sign-extended
    logic                   bren;
    br_func_e               br_func;
    logic                   gpr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    mem_op_e                mem_op;
    logic                   ebreak;
    logic                   invalid;
    logic [GPR_ADDR_WD-1:0] rd;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [IMM_WD-1:0] imm;
    logic [XLEN-1:0]   pc;
    ctrl_t             ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        result;
  } bypass_t;

  typedef struct packed {
    logic                   wen;
    logic [GPR_ADDR_WD-1:0] waddr;
    logic [XLEN-1:0]        wdata;
  } rf_write_t;

  typedef struct packed {
    logic            taken;
    logic            sel;
    logic [XLEN-1:0] target;
  } br_bus_t;

endpackage

`default_nettype wire

//--- id_stage/id_stage.sv
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module id_stage
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  // from fetch
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds,
  output logic      o_ds_allowin,
  // to execute
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es,
  input  logic      i_es_allowin,
  // write back port and bypass buses
  input  rf_write_t i_rf_write,
  input  bypass_t   i_es_bypass,
  input  bypass_t   i_ms_bypass,
  input  bypass_t   i_ws_bypass,
  // redirect to fetch
  output br_bus_t   o_br_bus
);

  logic                   ds_valid;
  logic                   ds_ready_go;
  logic                   ebreak_wait;
  fs_to_ds_t              ds_word;
  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic [IMM_WD-1:0]      imm;
  ctrl_t                  ctrl;
  logic [XLEN-1:0]        rf_rdata1;
  logic [XLEN-1:0]        rf_rdata2;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;
  logic                   br_sel;
  logic [XLEN-1:0]        br_target;
  logic                   br_taken;

  // ebreak must see a0 fully written back
  assign ebreak_wait = ctrl.ebreak &&
                       (i_es_bypass.rd == EBREAK_WAIT_REG ||
                        i_ms_bypass.rd == EBREAK_WAIT_REG ||
                        i_ws_bypass.rd == EBREAK_WAIT_REG);

  assign ds_ready_go      = !ebreak_wait;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !br_taken; // wrong-path slot dropped
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_word <= i_fs_to_ds;
    end
  end

  // redirect only when fetch is not already on the target
  assign br_taken = ds_valid && br_sel && (br_target != i_fs_to_ds.pc);
  assign o_br_bus = '{taken: br_taken, sel: ds_valid && br_sel, target: br_target};

  assign o_ds_to_es = '{
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    imm:      imm,
    pc:       ds_word.pc,
    ctrl:     ctrl
  };

  inst_decoder u_decoder (
    .i_inst (ds_word.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_write  (i_rf_write)
  );

  operand_bypass u_bypass (
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_rf_rdata1 (rf_rdata1),
    .i_rf_rdata2 (rf_rdata2),
    .i_es_bypass (i_es_bypass),
    .i_ms_bypass (i_ms_bypass),
    .i_ws_bypass (i_ws_bypass),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data)
  );

  branch_unit u_branch (
    .i_ctrl      (ctrl),
    .i_pc        (ds_word.pc),
    .i_imm       (imm),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .o_br_sel    (br_sel),
    .o_br_target (br_target)
  );

endmodule

`default_nettype wire

//--- src/branch_unit.sv
// branch and jump resolution
`timescale 1ns/1ps
`default_nettype none

module branch_unit
  import id_pkg::*;
(
  input  ctrl_t             i_ctrl,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [IMM_WD-1:0] i_imm,
  input  logic [XLEN-1:0]   i_rs1_data,
  input  logic [XLEN-1:0]   i_rs2_data,
  output logic              o_br_sel,
  output logic [XLEN-1:0]   o_br_target
);

  logic [XLEN-1:0] pc_imm;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] jalr_sum;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;

  assign pc_imm   = i_pc + i_imm;
  assign pc_seq   = i_pc + XLEN'(4);
  assign jalr_sum = i_rs1_data + i_imm;

  // compares use the forwarded operands
  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_ctrl.br_func)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt;
      BR_BGE:  cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      BR_JAL:  cond = 1'b1;
      BR_JALR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  // not-taken branches still report pc + 4
  assign o_br_target = (i_ctrl.br_func == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} :
                       cond                        ? pc_imm                     :
                                                     pc_seq;

  assign o_br_sel = i_ctrl.bren && !i_ctrl.invalid;

endmodule

`default_nettype wire

//--- src/gpr_file.sv
// general purpose register file
`timescale 1ns/1ps
`default_nettype none

module gpr_file
  import id_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2,
  input  rf_write_t              i_write
);

  logic [XLEN-1:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_write.wen && i_write.waddr != '0) begin
      regs[i_write.waddr] <= i_write.wdata;
    end
  end

  // no write-through so a write shows up the cycle after
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
// rv64i instruction decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import id_pkg::*;
(
  input  logic [INST_WD-1:0]     i_inst,
  output logic [GPR_ADDR_WD-1:0] o_rs1,
  output logic [GPR_ADDR_WD-1:0] o_rs2,
  output logic [IMM_WD-1:0]      o_imm,
  output ctrl_t                  o_ctrl
);

  opcode_e           opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [IMM_WD-1:0] imm_i;
  logic [IMM_WD-1:0] imm_s;
  logic [IMM_WD-1:0] imm_b;
  logic [IMM_WD-1:0] imm_u;
  logic [IMM_WD-1:0] imm_j;
  logic              f7_ok;     // register forms
  logic              sh6_ok;    // rv64 shift-immediate forms
  logic              shift_alt; // srai / sraiw
  logic              legal;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{(IMM_WD-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(IMM_WD-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(IMM_WD-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(IMM_WD-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(IMM_WD-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // alternate funct7 only for sub and sra
  assign f7_ok = (funct7 == 7'b0000000) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign sh6_ok = (i_inst[31:26] == 6'b000000) ||
                  (i_inst[31:26] == 6'b010000 && funct3 == 3'b101);
  assign shift_alt = (funct3 == 3'b101) && i_inst[30];

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.alu_op   = ALU_ADD;
    o_ctrl.src1_sel = SRC1_RS1;
    o_ctrl.src2_sel = SRC2_RS2;
    o_ctrl.br_func  = BR_BEQ;
    o_ctrl.mem_op   = MEM_B;
    o_imm           = imm_i;
    legal           = 1'b1;
    case (opcode)
      OPC_OP, OPC_OP_32: begin
        o_ctrl.alu_op   = alu_from_f3(funct3, funct7[5]);
        o_ctrl.word_cut = (opcode == OPC_OP_32);
        o_ctrl.gpr_wen  = 1'b1;
        legal = f7_ok && (opcode == OPC_OP || funct3 inside {3'b000, 3'b001, 3'b101});
      end
      OPC_OP_IMM: begin
        o_ctrl.alu_op   = alu_from_f3(funct3, shift_alt);
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        legal           = !(funct3 inside {3'b001, 3'b101}) || sh6_ok;
      end
      OPC_OP_IMM_32: begin
        o_ctrl.alu_op   = alu_from_f3(funct3, shift_alt);
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.word_cut = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        legal = (funct3 == 3'b000) || (funct3 inside {3'b001, 3'b101} && f7_ok);
      end
      OPC_LUI: begin
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      OPC_JAL, OPC_JALR: begin
        o_ctrl.src1_sel = SRC1_PC;   // link value pc + 4
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.bren     = 1'b1;
        o_ctrl.br_func  = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = (opcode == OPC_JAL) ? imm_j : imm_i;
        legal           = (opcode == OPC_JAL) || (funct3 == 3'b000);
      end
      OPC_BRANCH: begin
        o_ctrl.bren = 1'b1;
        o_imm       = imm_b;
        case (funct3)
          3'b000:  o_ctrl.br_func = BR_BEQ;
          3'b001:  o_ctrl.br_func = BR_BNE;
          3'b100:  o_ctrl.br_func = BR_BLT;
          3'b101:  o_ctrl.br_func = BR_BGE;
          3'b110:  o_ctrl.br_func = BR_BLTU;
          3'b111:  o_ctrl.br_func = BR_BGEU;
          default: legal = 1'b0;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.mem_op   = mem_op_e'(funct3);
        o_ctrl.mem_ren  = (opcode == OPC_LOAD);
        o_ctrl.mem_wen  = (opcode == OPC_STORE);
        o_ctrl.gpr_wen  = (opcode == OPC_LOAD);
        o_imm           = (opcode == OPC_LOAD) ? imm_i : imm_s;
        legal = (opcode == OPC_LOAD) ? (funct3 != 3'b111) : (funct3[2] == 1'b0);
      end
      OPC_SYSTEM: begin
        // only ebreak with all other fields zero
        legal         = (i_inst[31:20] == 12'h001) && (i_inst[19:7] == '0);
        o_ctrl.ebreak = legal;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      o_ctrl         = '0;
      o_ctrl.invalid = 1'b1;
      o_imm          = '0;
    end
    o_ctrl.rd = o_ctrl.gpr_wen ? i_inst[11:7] : '0;
  end

endmodule

`default_nettype wire

//--- src/operand_bypass.sv
// source operand forwarding
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
  import id_pkg::*;
(
  input  logic [GPR_ADDR_WD-1:0] i_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_rs2,
  input  logic [XLEN-1:0]        i_rf_rdata1,
  input  logic [XLEN-1:0]        i_rf_rdata2,
  input  bypass_t                i_es_bypass,
  input  bypass_t                i_ms_bypass,
  input  bypass_t                i_ws_bypass,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data
);

  // youngest producer wins
  function automatic logic [XLEN-1:0] forward(
    input logic [GPR_ADDR_WD-1:0] rs,
    input logic [XLEN-1:0]        rf_data,
    input bypass_t                es,
    input bypass_t                ms,
    input bypass_t                ws
  );
    logic [XLEN-1:0] data;
    data = rf_data;
    if (rs != '0) begin // x0 never forwarded
      if (rs == es.rd) begin
        data = es.result;
      end else if (rs == ms.rd) begin
        data = ms.result;
      end else if (rs == ws.rd) begin
        data = ws.result;
      end
    end
    return data;
  endfunction

  assign o_rs1_data = forward(i_rs1, i_rf_rdata1, i_es_bypass, i_ms_bypass, i_ws_bypass);
  assign o_rs2_data = forward(i_rs2, i_rf_rdata2, i_es_bypass, i_ms_bypass, i_ws_bypass);

endmodule

`default_nettype wire

//--- tb.f
common/id_pkg.sv
src/inst_decoder.sv
src/gpr_file.sv
src/operand_bypass.sv
src/branch_unit.sv
id_stage/id_stage.sv
bench/id_stage_props.sv
bench/tb_id_stage.sv
